/* mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int WORD_BITS     = 32;
    localparam int REG_ADDR_BITS = 5;

    // Major opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, see funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

/* mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_HALTED = 3'd0,
        ST_FETCH  = 3'd1,
        ST_DECODE = 3'd2,
        ST_EXEC1  = 3'd3,
        ST_EXEC2  = 3'd4   // LW write-back only
    } cpu_state_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,   // Signed
        ALU_EQ  = 4'd6,
        ALU_NE  = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_ALU    = 2'd0,  // PC + 4 straight from the ALU
        PC_BRANCH = 2'd1,  // Target held in alu_out
        PC_JUMP   = 2'd2,
        PC_REG    = 2'd3
    } pc_src_e;

    typedef enum logic [2:0] {
        SRCB_REG        = 3'd0,
        SRCB_FOUR       = 3'd1,
        SRCB_SIGN_IMM   = 3'd2,
        SRCB_BRANCH_OFS = 3'd3,  // Sign-extended immediate times four
        SRCB_ZERO_IMM   = 3'd4
    } alu_src_b_e;

    typedef enum logic {
        DST_RT = 1'b0,
        DST_RD = 1'b1
    } reg_dst_e;

endpackage

/* mips_cpu_sequencer.sv */
module mips_cpu_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      three_cycle,
    input  logic                      read,
    input  logic                      write,
    input  logic                      waitrequest,
    input  logic                      halt_jump,
    output mips_ctrl_pkg::cpu_state_e state,
    output logic                      active
);
    import mips_ctrl_pkg::*;

    cpu_state_e state_next;
    logic       bus_stall;

    assign bus_stall = (read || write) && waitrequest;  // Hold until the transfer completes
    assign active    = (state != ST_HALTED);

    always_comb begin
        state_next = state;
        if (halt_jump) begin
            state_next = ST_HALTED;
        end else if (!bus_stall) begin
            case (state)
                ST_FETCH:  state_next = ST_DECODE;
                ST_DECODE: state_next = ST_EXEC1;
                ST_EXEC1:  state_next = three_cycle ? ST_FETCH : ST_EXEC2;
                ST_EXEC2:  state_next = ST_FETCH;
                default:   state_next = state;  // Halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* mips_cpu_controller.sv */
module mips_cpu_controller (
    input  mips_ctrl_pkg::cpu_state_e             state,
    input  logic [mips_isa_pkg::WORD_BITS-1:0]    instruction,
    input  logic [1:0]                            mem_addr_low,
    output logic                                  three_cycle,
    output logic                                  pc_write,
    output logic                                  pc_write_cond,
    output mips_ctrl_pkg::pc_src_e                pc_source,
    output logic                                  ir_write,
    output logic                                  i_or_d,
    output logic                                  read,
    output logic                                  write,
    output logic [3:0]                            byteenable,
    output logic                                  reg_write,
    output mips_ctrl_pkg::reg_dst_e               reg_dst,
    output logic                                  mem_to_reg,
    output mips_ctrl_pkg::alu_op_e                alu_op,
    output logic                                  alu_src_a,
    output mips_ctrl_pkg::alu_src_b_e             alu_src_b,
    output logic                                  alu_out_en
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instruction[31:26]);
    assign funct  = funct_e'(instruction[5:0]);

    always_comb begin
        three_cycle   = (opcode != OP_LW);
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        pc_source     = PC_ALU;
        ir_write      = 1'b0;
        i_or_d        = 1'b0;
        read          = 1'b0;
        write         = 1'b0;
        byteenable    = 4'b0000;
        reg_write     = 1'b0;
        reg_dst       = DST_RT;
        mem_to_reg    = 1'b0;
        alu_op        = ALU_ADD;
        alu_src_a     = 1'b0;
        alu_src_b     = SRCB_REG;
        alu_out_en    = 1'b0;

        case (state)
            ST_FETCH: begin
                read       = 1'b1;
                byteenable = 4'b1111;
                ir_write   = 1'b1;
                pc_write   = 1'b1;        // PC + 4
                alu_src_b  = SRCB_FOUR;
            end
            ST_DECODE: begin
                alu_src_b  = SRCB_BRANCH_OFS;  // Branch target into alu_out
                alu_out_en = 1'b1;
            end
            ST_EXEC1: begin
                alu_src_a = 1'b1;
                case (opcode)
                    OP_SPECIAL: begin
                        if (funct == FN_JR) begin
                            pc_write  = 1'b1;
                            pc_source = PC_REG;
                        end else begin
                            reg_write  = 1'b1;
                            reg_dst    = DST_RD;
                            alu_out_en = 1'b1;
                            case (funct)
                                FN_SUBU: alu_op = ALU_SUB;
                                FN_AND:  alu_op = ALU_AND;
                                FN_OR:   alu_op = ALU_OR;
                                FN_XOR:  alu_op = ALU_XOR;
                                FN_SLT:  alu_op = ALU_SLT;
                                default: alu_op = ALU_ADD;
                            endcase
                        end
                    end
                    OP_J: begin
                        pc_write  = 1'b1;
                        pc_source = PC_JUMP;
                    end
                    OP_BEQ, OP_BNE: begin
                        pc_write_cond = 1'b1;
                        pc_source     = PC_BRANCH;
                        alu_op        = (opcode == OP_BEQ) ? ALU_EQ : ALU_NE;
                    end
                    OP_ADDIU, OP_ANDI, OP_ORI: begin
                        reg_write  = 1'b1;
                        alu_out_en = 1'b1;
                        alu_src_b  = (opcode == OP_ADDIU) ? SRCB_SIGN_IMM : SRCB_ZERO_IMM;
                        if (opcode == OP_ANDI) alu_op = ALU_AND;
                        if (opcode == OP_ORI) alu_op = ALU_OR;
                    end
                    OP_LW: begin
                        i_or_d     = 1'b1;
                        read       = 1'b1;
                        byteenable = 4'b1111;
                        mem_to_reg = 1'b1;
                        alu_src_b  = SRCB_SIGN_IMM;
                    end
                    OP_SW, OP_SH, OP_SB: begin
                        i_or_d    = 1'b1;
                        write     = 1'b1;
                        alu_src_b = SRCB_SIGN_IMM;
                        if (opcode == OP_SW) begin
                            byteenable = 4'b1111;
                        end else if (opcode == OP_SH) begin
                            byteenable = mem_addr_low[1] ? 4'b1100 : 4'b0011;
                        end else begin
                            byteenable = 4'b0001 << mem_addr_low;  // Little-endian lane
                        end
                    end
                    default: ;
                endcase
            end
            ST_EXEC2: begin
                reg_write  = 1'b1;  // LW result from the data register
                mem_to_reg = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* mips_cpu_fetch_unit.sv */
module mips_cpu_fetch_unit #(
    parameter logic [mips_isa_pkg::WORD_BITS-1:0] RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pc_write,
    input  logic                               pc_write_cond,
    input  logic                               cond,
    input  mips_ctrl_pkg::pc_src_e             pc_source,
    input  logic                               ir_write,
    input  logic                               i_or_d,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] readdata,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] alu_result,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] alu_out,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] reg_a,
    input  logic                               waitrequest,
    output logic [mips_isa_pkg::WORD_BITS-1:0] instruction,
    output logic [mips_isa_pkg::WORD_BITS-1:0] pc,
    output logic [mips_isa_pkg::WORD_BITS-1:0] address,
    output logic                               halt_jump
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [WORD_BITS-1:0] pc_next;
    logic                 pc_en;

    always_comb begin
        case (pc_source)
            PC_BRANCH: pc_next = alu_out;
            PC_JUMP:   pc_next = {pc[31:28], instruction[25:0], 2'b00};
            PC_REG:    pc_next = reg_a;
            default:   pc_next = alu_result;
        endcase
    end

    // Fetch advances the PC only together with the IR load
    assign pc_en     = (pc_write && !(ir_write && waitrequest)) || (pc_write_cond && cond);
    assign halt_jump = pc_write && (pc_source == PC_JUMP || pc_source == PC_REG)
                       && (pc_next == '0);
    assign address   = i_or_d ? alu_result : pc;  // Data address is live during exec1

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write && !waitrequest) begin
            instruction <= readdata;
        end
    end

endmodule

/* mips_cpu_register_stage.sv */
module mips_cpu_register_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] instruction,
    input  logic                               reg_write,
    input  mips_ctrl_pkg::reg_dst_e            reg_dst,
    input  logic                               mem_to_reg,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] alu_out,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] readdata,
    output logic [mips_isa_pkg::WORD_BITS-1:0] reg_a,
    output logic [mips_isa_pkg::WORD_BITS-1:0] reg_b,
    output logic [mips_isa_pkg::WORD_BITS-1:0] writedata,
    output logic [mips_isa_pkg::WORD_BITS-1:0] register_v0
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [WORD_BITS-1:0]     regs [2**REG_ADDR_BITS];
    logic [WORD_BITS-1:0]     mdr;
    logic [WORD_BITS-1:0]     wb_data;
    logic [REG_ADDR_BITS-1:0] rs;
    logic [REG_ADDR_BITS-1:0] rt;
    logic [REG_ADDR_BITS-1:0] dst;
    logic [REG_ADDR_BITS-1:0] wb_addr;
    logic                     wb_pending;
    logic                     wb_from_mem;
    opcode_e                  opcode;

    assign rs          = instruction[25:21];
    assign rt          = instruction[20:16];
    assign dst         = (reg_dst == DST_RD) ? instruction[15:11] : rt;
    assign opcode      = opcode_e'(instruction[31:26]);
    assign wb_data     = wb_from_mem ? mdr : alu_out;  // alu_out holds the result by now
    assign register_v0 = regs[2];

    always_comb begin
        case (opcode)
            OP_SB:   writedata = {4{reg_b[7:0]}};
            OP_SH:   writedata = {2{reg_b[15:0]}};
            default: writedata = reg_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_pending <= 1'b0;
        end else begin
            wb_pending <= reg_write;  // Commit one cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        wb_addr     <= dst;
        wb_from_mem <= mem_to_reg;
        if (mem_to_reg && !reg_write) begin
            mdr <= readdata;  // Last load is the completing read
        end
        reg_a <= (rs == '0) ? '0 : regs[rs];
        reg_b <= (rt == '0) ? '0 : regs[rt];
        if (wb_pending && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

/* mips_cpu_execute.sv */
module mips_cpu_execute (
    input  logic                               clk,
    input  logic                               rst,
    input  mips_ctrl_pkg::alu_op_e             alu_op,
    input  logic                               alu_src_a,
    input  mips_ctrl_pkg::alu_src_b_e          alu_src_b,
    input  logic                               alu_out_en,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] pc,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] reg_a,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] reg_b,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] instruction,
    output logic [mips_isa_pkg::WORD_BITS-1:0] alu_result,
    output logic [mips_isa_pkg::WORD_BITS-1:0] alu_out,
    output logic                               cond
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [WORD_BITS-1:0] src_a;
    logic [WORD_BITS-1:0] src_b;
    logic [15:0]          imm;

    assign imm   = instruction[15:0];
    assign src_a = alu_src_a ? reg_a : pc;

    always_comb begin
        case (alu_src_b)
            SRCB_FOUR:       src_b = 32'd4;
            SRCB_SIGN_IMM:   src_b = {{16{imm[15]}}, imm};
            SRCB_BRANCH_OFS: src_b = {{14{imm[15]}}, imm, 2'b00};
            SRCB_ZERO_IMM:   src_b = {16'h0000, imm};
            default:         src_b = reg_b;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_XOR: alu_result = src_a ^ src_b;
            ALU_SLT: alu_result = {{(WORD_BITS-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_EQ:  alu_result = {{(WORD_BITS-1){1'b0}}, src_a == src_b};
            ALU_NE:  alu_result = {{(WORD_BITS-1){1'b0}}, src_a != src_b};
            default: alu_result = src_a + src_b;
        endcase
    end

    assign cond = (alu_op == ALU_EQ || alu_op == ALU_NE) && alu_result[0];  // Branch taken

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_out <= '0;
        end else if (alu_out_en) begin
            alu_out <= alu_result;
        end
    end

endmodule

/* mips_cpu_bus.sv */
module mips_cpu_bus #(
    parameter logic [mips_isa_pkg::WORD_BITS-1:0] RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic                               clk,
    input  logic                               rst,
    output logic                               active,
    output logic [mips_isa_pkg::WORD_BITS-1:0] register_v0,
    output logic [mips_isa_pkg::WORD_BITS-1:0] address,
    output logic                               read,
    output logic                               write,
    output logic [3:0]                         byteenable,
    output logic [mips_isa_pkg::WORD_BITS-1:0] writedata,
    input  logic [mips_isa_pkg::WORD_BITS-1:0] readdata,
    input  logic                               waitrequest
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    cpu_state_e           state;
    pc_src_e              pc_source;
    reg_dst_e             reg_dst;
    alu_op_e              alu_op;
    alu_src_b_e           alu_src_b;
    logic                 three_cycle;
    logic                 halt_jump;
    logic                 pc_write;
    logic                 pc_write_cond;
    logic                 ir_write;
    logic                 i_or_d;
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 alu_src_a;
    logic                 alu_out_en;
    logic                 cond;
    logic [WORD_BITS-1:0] instruction;
    logic [WORD_BITS-1:0] pc;
    logic [WORD_BITS-1:0] alu_result;
    logic [WORD_BITS-1:0] alu_out;
    logic [WORD_BITS-1:0] reg_a;
    logic [WORD_BITS-1:0] reg_b;

    mips_cpu_sequencer u_sequencer (.*);

    mips_cpu_controller u_controller (
        .mem_addr_low (alu_result[1:0]),  // Store lanes from the live address
        .*
    );

    mips_cpu_fetch_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch_unit (.*);

    mips_cpu_register_stage u_register_stage (.*);

    mips_cpu_execute u_execute (.*);

endmodule

/* tb_mips_cpu_bus.sv */
module tb_mips_cpu_bus;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;

    localparam logic [WORD_BITS-1:0] RESET_VECTOR = 32'hbfc0_0000;
    localparam int MEM_WORDS   = 1024;   // Window on address bits 11:2
    localparam int STIM_WORDS  = 512;
    localparam int RUN_TIMEOUT = 5000;   // Cycles from reset release to halt

    logic                 clk;
    logic                 rst;
    logic                 active;
    logic [WORD_BITS-1:0] register_v0;
    logic [WORD_BITS-1:0] address;
    logic                 read;
    logic                 write;
    logic [3:0]           byteenable;
    logic [WORD_BITS-1:0] writedata;
    logic [WORD_BITS-1:0] readdata;
    logic                 waitrequest;

    logic [WORD_BITS-1:0] mem [MEM_WORDS];
    logic [WORD_BITS-1:0] stim [STIM_WORDS];
    logic [WORD_BITS-1:0] exp_addr [$];
    logic [WORD_BITS-1:0] exp_data [$];
    integer               seed;
    logic                 random_wait;

    mips_cpu_bus #(
        .RESET_VECTOR (RESET_VECTOR)
    ) uut (.*);

    always #50 clk = ~clk;

    function automatic logic [9:0] word_index(input logic [WORD_BITS-1:0] addr);
        return addr[11:2];
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] expected,
                              input logic [WORD_BITS-1:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAILED %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAILED %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
        end
    endtask

    // Memory model bus cycle on the falling edge
    task automatic bus_cycle();
        logic [9:0]           idx;
        logic [WORD_BITS-1:0] mask;
        @(negedge clk);
        waitrequest = random_wait && (($random(seed) % 3) == 0);
        idx = word_index(address);
        if (write && !waitrequest) begin  // Transfer completes this cycle
            mask = {{8{byteenable[3]}}, {8{byteenable[2]}},
                    {8{byteenable[1]}}, {8{byteenable[0]}}};
            mem[idx] = (mem[idx] & ~mask) | (writedata & mask);
        end
        readdata = read ? mem[idx] : 'x;  // Only valid for a read
    endtask

    task automatic reset_and_run();
        int cycles;
        rst = 1'b1;
        repeat (8) bus_cycle();
        rst = 1'b0;
        check_flag("active", 1'b1, active);
        check_flag("read", 1'b1, read);
        check_flag("write", 1'b0, write);
        check_word("address", RESET_VECTOR, address);  // First fetch
        cycles = 0;
        while (active !== 1'b0 && cycles < RUN_TIMEOUT) begin
            bus_cycle();
            cycles++;
        end
        if (active !== 1'b0) begin
            stop_with_error($sformatf("Timeout: CPU did not halt within %0d cycles",
                                      RUN_TIMEOUT));
        end
    endtask

    initial begin
        int         i;
        int         k;
        int         pass;
        int         test_count;
        logic [8:0] pos;
        clk         = 1'b0;
        rst         = 1'b1;
        readdata    = '0;
        waitrequest = 1'b0;
        seed        = 84522;
        random_wait = 1'b0;
        test_count  = 0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a5a_c3c3 ^ (i * 32'h0004_0101);
        end
        $readmemh("mips_stim.txt", stim);

        for (pass = 0; pass < 2; pass++) begin
            random_wait = (pass == 1);  // Second pass with back-pressure
            pos = '0;
            while (pos < 9'd510 && stim[pos] != '0) begin
                case (stim[pos])
                    32'd1: mem[word_index(stim[pos + 9'd1])] = stim[pos + 9'd2];
                    32'd2: begin
                        exp_addr.push_back(stim[pos + 9'd1]);
                        exp_data.push_back(stim[pos + 9'd2]);
                    end
                    32'd3: begin
                        reset_and_run();
                        check_word("register_v0", stim[pos + 9'd2], register_v0);
                        for (k = 0; k < exp_addr.size(); k++) begin
                            check_word($sformatf("mem[0x%h]", exp_addr[k]), exp_data[k],
                                       mem[word_index(exp_addr[k])]);
                        end
                        exp_addr.delete();
                        exp_data.delete();
                        test_count++;
                    end
                    default: stop_with_error("Unknown record kind in mips_stim.txt");
                endcase
                pos = pos + 9'd3;
            end
        end

        if (test_count > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_with_error("No test records were found in mips_stim.txt");
        end
    end

endmodule

/* mips_stim.txt */
// Columns: kind address data. Kind 1 preloads a word, 2 is an expected memory word,
// 3 is the expected v0 and runs the test (address unused), 0 ends the file.
// ALU program
1 bfc00000 24081234
1 bfc00004 2409fff0
1 bfc00008 01095021
1 bfc0000c 01095823
1 bfc00010 01096024
1 bfc00014 01096825
1 bfc00018 014b7026
1 bfc0001c 0128782a
1 bfc00020 31b80ff0
1 bfc00024 37198001
1 bfc00028 018e1021
1 bfc0002c 004f1021
1 bfc00030 00591026
1 bfc00034 004b1023
1 bfc00038 00000008
3 00000000 00008b1c
// Branches, jump and a backward loop
1 bfc00000 24020001
1 bfc00004 24080005
1 bfc00008 24090005
1 bfc0000c 11090001
1 bfc00010 24420100
1 bfc00014 15090001
1 bfc00018 24420002
1 bfc0001c 11000001
1 bfc00020 24420004
1 bfc00024 15000001
1 bfc00028 24420200
1 bfc0002c 0bf0000d
1 bfc00030 24420400
1 bfc00034 24420008
1 bfc00038 2508ffff
1 bfc0003c 24420010
1 bfc00040 1500fffd
1 bfc00044 00000008
3 00000000 0000005f
// Stores at every lane, then loads
1 bfc00000 24080400
1 bfc00004 24098765
1 bfc00008 240a00a1
1 bfc0000c 240b5bc2
1 bfc00010 240e00b2
1 bfc00014 ad090000
1 bfc00018 ad090004
1 bfc0001c ad090008
1 bfc00020 a50b0000
1 bfc00024 a10e0002
1 bfc00028 a10a0004
1 bfc0002c a10e0005
1 bfc00030 a10a0007
1 bfc00034 a50b000a
1 bfc00038 8d0c0000
1 bfc0003c 8d0d0004
1 bfc00040 018d1026
1 bfc00044 00000008
2 00000400 ffb25bc2
2 00000404 a1ffb2a1
2 00000408 5bc28765
3 00000000 5e4de963
0 00000000 00000000

/* build.f */
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_cpu_sequencer.sv
mips_cpu_controller.sv
mips_cpu_fetch_unit.sv
mips_cpu_register_stage.sv
mips_cpu_execute.sv
mips_cpu_bus.sv
tb_mips_cpu_bus.sv

/* Makefile */
# Verilator build and run of the MIPS CPU testbench

TOP := tb_mips_cpu_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir
